// File: hca_macros.svh
//**********************************************************
// Widths, APB register offsets and pipeline latency
// of the 64-bit hybrid prefix adder.
//**********************************************************

`ifndef HCA_MACROS_SVH
`define HCA_MACROS_SVH

`define HCA_WIDTH       64      // operand and sum width.
`define HCA_APB_AW      8
`define HCA_APB_DW      32

// each register offset holds one 32-bit word.
`define HCA_REG_A_LO    8'h00
`define HCA_REG_A_HI    8'h04
`define HCA_REG_B_LO    8'h08
`define HCA_REG_B_HI    8'h0C
`define HCA_REG_CTRL    8'h10   // bit 0 carry-in, bit 1 start.
`define HCA_REG_STATUS  8'h14   // bit 0 done, bit 1 carry-out, bit 2 busy.
`define HCA_REG_SUM_LO  8'h18
`define HCA_REG_SUM_HI  8'h1C

// Control register bit positions.
`define HCA_CTRL_CIN    0
`define HCA_CTRL_START  1

`define HCA_LATENCY     2       // cycles from launch to result.

`endif

// File: hca_pkg.sv
//**********************************************************
// Vector types shared by the adder RTL and its testbench.
//**********************************************************

`default_nettype none

`include "hca_macros.svh"

package hca_pkg;

        // one operand or one sum.
        typedef logic [`HCA_WIDTH-1:0] operand_t;

        // a propagate or generate vector whose position 0 holds the carry-in.
        typedef logic [`HCA_WIDTH:0] pg_vec_t;

        typedef logic [`HCA_APB_AW-1:0] apb_addr_t;

        typedef logic [`HCA_APB_DW-1:0] apb_data_t;

        // enough to count every addition the pipeline can hold.
        typedef logic [$clog2(`HCA_LATENCY + 1)-1:0] flight_cnt_t;

endpackage

`default_nettype wire

// File: hca_apb_regs.sv
//**********************************************************
// APB slave of the hybrid adder: operand and control
// registers, launch pulse, in-flight count, result copy,
// read stall while busy and read data mux.
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hca_macros.svh"

module hca_apb_regs (
        input  logic                clk,
        input  logic                rst,
        input  hca_pkg::apb_addr_t  paddr,
        input  logic                psel,
        input  logic                penable,
        input  logic                pwrite,
        input  hca_pkg::apb_data_t  pwdata,
        input  logic                res_valid,
        input  hca_pkg::operand_t   res_sum,
        input  logic                res_cout,
        output hca_pkg::apb_data_t  prdata,
        output logic                pready,
        output logic                pslverr,
        output logic                launch,
        output hca_pkg::operand_t   op_a,
        output hca_pkg::operand_t   op_b,
        output logic                cin
);

        hca_pkg::operand_t    sum_q;
        logic                 cout_q;
        logic                 done_q;
        hca_pkg::flight_cnt_t flight_cnt;

        logic xfer_done;
        logic wr_en;
        logic start_wr;
        logic busy;
        logic rd_result;
        logic addr_err;
        logic stall;

        assign xfer_done = psel & penable & pready;
        assign wr_en     = xfer_done & pwrite;
        assign start_wr  = wr_en & (paddr == `HCA_REG_CTRL) & pwdata[`HCA_CTRL_START];
        assign busy      = (flight_cnt != '0);
        assign stall     = rd_result & busy;

        always_comb begin
                rd_result = 1'b0;
                addr_err  = 1'b0;
                case (paddr)
                        `HCA_REG_STATUS, `HCA_REG_SUM_LO, `HCA_REG_SUM_HI: begin
                                rd_result = ~pwrite;
                                addr_err  = pwrite;     // these words are read only.
                        end
                        `HCA_REG_A_LO, `HCA_REG_A_HI, `HCA_REG_B_LO, `HCA_REG_B_HI,
                        `HCA_REG_CTRL: begin
                                addr_err = 1'b0;
                        end
                        default: begin
                                addr_err = 1'b1;
                        end
                endcase
        end

        // pready rises one cycle after the setup phase unless a result read must wait.
        always_ff @(posedge clk) begin
                if (rst) begin
                        pready  <= 1'b0;
                        pslverr <= 1'b0;
                end else begin
                        pready  <= psel & ~xfer_done & ~stall;
                        pslverr <= psel & ~xfer_done & ~stall & addr_err;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        op_a <= '0;
                        op_b <= '0;
                        cin  <= 1'b0;
                end else if (wr_en) begin
                        case (paddr)
                                `HCA_REG_A_LO: op_a[`HCA_APB_DW-1:0] <= pwdata;
                                `HCA_REG_A_HI: op_a[`HCA_WIDTH-1:`HCA_APB_DW] <= pwdata;
                                `HCA_REG_B_LO: op_b[`HCA_APB_DW-1:0] <= pwdata;
                                `HCA_REG_B_HI: op_b[`HCA_WIDTH-1:`HCA_APB_DW] <= pwdata;
                                `HCA_REG_CTRL: cin <= pwdata[`HCA_CTRL_CIN];
                                default: cin <= cin;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        launch <= 1'b0;
                end else begin
                        launch <= start_wr;     // the start bit clears itself.
                end
        end

        // The count rises on the same edge as launch so a following read stalls.
        always_ff @(posedge clk) begin
                if (rst) begin
                        flight_cnt <= '0;
                end else begin
                        case ({start_wr, res_valid})
                                2'b10: flight_cnt <= flight_cnt + hca_pkg::flight_cnt_t'(1);
                                2'b01: flight_cnt <= flight_cnt - hca_pkg::flight_cnt_t'(1);
                                default: flight_cnt <= flight_cnt;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        sum_q  <= '0;
                        cout_q <= 1'b0;
                        done_q <= 1'b0;
                end else begin
                        if (res_valid) begin
                                sum_q  <= res_sum;
                                cout_q <= res_cout;
                        end
                        if (start_wr) begin
                                done_q <= 1'b0;
                        end else if (res_valid) begin
                                done_q <= 1'b1;
                        end
                end
        end

        always_comb begin
                prdata = '0;
                case (paddr)
                        `HCA_REG_A_LO:   prdata = op_a[`HCA_APB_DW-1:0];
                        `HCA_REG_A_HI:   prdata = op_a[`HCA_WIDTH-1:`HCA_APB_DW];
                        `HCA_REG_B_LO:   prdata = op_b[`HCA_APB_DW-1:0];
                        `HCA_REG_B_HI:   prdata = op_b[`HCA_WIDTH-1:`HCA_APB_DW];
                        `HCA_REG_CTRL:   prdata[`HCA_CTRL_CIN] = cin;
                        `HCA_REG_STATUS: prdata[2:0] = {busy, cout_q, done_q};
                        `HCA_REG_SUM_LO: prdata = sum_q[`HCA_APB_DW-1:0];
                        `HCA_REG_SUM_HI: prdata = sum_q[`HCA_WIDTH-1:`HCA_APB_DW];
                        default:         prdata = '0;
                endcase
        end

endmodule

`default_nettype wire

// File: hca_prefix_tree.sv
//**********************************************************
// Prefix tree of the hybrid adder: propagate and generate,
// Brent-Kung pairing and Kogge-Stone levels on odd
// positions, one pipeline register after the span-4 level.
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hca_macros.svh"

module hca_prefix_tree (
        input  logic              clk,
        input  logic              rst,
        input  logic              launch,
        input  hca_pkg::operand_t op_a,
        input  hca_pkg::operand_t op_b,
        input  logic              cin,
        output logic              tree_valid,
        output hca_pkg::pg_vec_t  tree_gnpg,
        output hca_pkg::pg_vec_t  tree_pp,
        output hca_pkg::pg_vec_t  tree_p
);

        localparam int PRE_LEVELS  = 3; // pairing, span 2 and span 4.
        localparam int POST_LEVELS = 3; // span 8, span 16 and span 32.

        hca_pkg::pg_vec_t gn_pre  [PRE_LEVELS+1];
        hca_pkg::pg_vec_t pp_pre  [PRE_LEVELS+1];
        hca_pkg::pg_vec_t gn_post [POST_LEVELS+1];
        hca_pkg::pg_vec_t pp_post [POST_LEVELS+1];
        hca_pkg::pg_vec_t gn_mid;
        hca_pkg::pg_vec_t pp_mid;

        // Combines each odd position with the one span below it.
        // Even positions and those too low to reach back pass unchanged.
        function automatic void prefix_level(
                input  int               span,
                input  hca_pkg::pg_vec_t gn_in,
                input  hca_pkg::pg_vec_t pp_in,
                output hca_pkg::pg_vec_t gn_out,
                output hca_pkg::pg_vec_t pp_out);
                gn_out = gn_in;
                pp_out = pp_in;
                for (int i = 1; i < `HCA_WIDTH; i += 2) begin
                        if (i >= span) begin
                                gn_out[i] = gn_in[i] | (pp_in[i] & gn_in[i - span]);
                                pp_out[i] = pp_in[i] & pp_in[i - span];
                        end
                end
        endfunction

        always_comb begin
                gn_pre[0] = {op_a & op_b, cin};         // carry-in acts as generate at 0.
                pp_pre[0] = {op_a ^ op_b, 1'b0};
                for (int lv = 1; lv <= PRE_LEVELS; lv++) begin
                        prefix_level(1 << (lv - 1), gn_pre[lv-1], pp_pre[lv-1],
                                     gn_pre[lv], pp_pre[lv]);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        tree_valid <= 1'b0;
                end else begin
                        tree_valid <= launch;
                end
        end

        always_ff @(posedge clk) begin
                if (launch) begin
                        gn_mid <= gn_pre[PRE_LEVELS];
                        pp_mid <= pp_pre[PRE_LEVELS];
                        tree_p <= pp_pre[0];    // raw propagate for the sum.
                end
        end

        always_comb begin
                gn_post[0] = gn_mid;
                pp_post[0] = pp_mid;
                for (int lv = 1; lv <= POST_LEVELS; lv++) begin
                        prefix_level(1 << (PRE_LEVELS + lv - 1), gn_post[lv-1], pp_post[lv-1],
                                     gn_post[lv], pp_post[lv]);
                end
        end

        // odd positions now hold the group generate from position 0.
        assign tree_gnpg = gn_post[POST_LEVELS];
        assign tree_pp   = pp_post[POST_LEVELS];

endmodule

`default_nettype wire

// File: hca_sum_stage.sv
//**********************************************************
// Final prefix level on even positions, sum and carry-out,
// with the result register.
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hca_macros.svh"

module hca_sum_stage (
        input  logic              clk,
        input  logic              rst,
        input  logic              tree_valid,
        input  hca_pkg::pg_vec_t  tree_gnpg,
        input  hca_pkg::pg_vec_t  tree_pp,
        input  hca_pkg::pg_vec_t  tree_p,
        output logic              res_valid,
        output hca_pkg::operand_t res_sum,
        output logic              res_cout
);

        hca_pkg::operand_t carry;       // carry into each sum bit.
        hca_pkg::operand_t sum_next;
        logic              cout_next;

        // each even position takes in the finished odd group just below it.
        always_comb begin
                carry = tree_gnpg[`HCA_WIDTH-1:0];
                for (int i = 2; i < `HCA_WIDTH; i += 2) begin
                        carry[i] = tree_gnpg[i] | (tree_pp[i] & tree_gnpg[i-1]);
                end
        end

        assign sum_next  = carry ^ tree_p[`HCA_WIDTH:1];
        assign cout_next = tree_gnpg[`HCA_WIDTH] |
                           (tree_pp[`HCA_WIDTH] & tree_gnpg[`HCA_WIDTH-1]);

        always_ff @(posedge clk) begin
                if (rst) begin
                        res_valid <= 1'b0;
                end else begin
                        res_valid <= tree_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (tree_valid) begin
                        res_sum  <= sum_next;
                        res_cout <= cout_next;
                end
        end

endmodule

`default_nettype wire

// File: hca_top.sv
//**********************************************************
// Top level of the APB hybrid prefix adder: register
// block, prefix tree and sum stage.
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module hca_top (
        input  logic               clk,
        input  logic               rst,
        input  hca_pkg::apb_addr_t paddr,
        input  logic               psel,
        input  logic               penable,
        input  logic               pwrite,
        input  hca_pkg::apb_data_t pwdata,
        output hca_pkg::apb_data_t prdata,
        output logic               pready,
        output logic               pslverr
);

        logic              launch;
        hca_pkg::operand_t op_a;
        hca_pkg::operand_t op_b;
        logic              cin;

        logic              tree_valid;
        hca_pkg::pg_vec_t  tree_gnpg;
        hca_pkg::pg_vec_t  tree_pp;
        hca_pkg::pg_vec_t  tree_p;

        logic              res_valid;
        hca_pkg::operand_t res_sum;
        logic              res_cout;

        hca_apb_regs u_regs (
                .clk       (clk),
                .rst       (rst),
                .paddr     (paddr),
                .psel      (psel),
                .penable   (penable),
                .pwrite    (pwrite),
                .pwdata    (pwdata),
                .res_valid (res_valid),
                .res_sum   (res_sum),
                .res_cout  (res_cout),
                .prdata    (prdata),
                .pready    (pready),
                .pslverr   (pslverr),
                .launch    (launch),
                .op_a      (op_a),
                .op_b      (op_b),
                .cin       (cin)
        );

        hca_prefix_tree u_tree (
                .clk        (clk),
                .rst        (rst),
                .launch     (launch),
                .op_a       (op_a),
                .op_b       (op_b),
                .cin        (cin),
                .tree_valid (tree_valid),
                .tree_gnpg  (tree_gnpg),
                .tree_pp    (tree_pp),
                .tree_p     (tree_p)
        );

        hca_sum_stage u_sum (
                .clk        (clk),
                .rst        (rst),
                .tree_valid (tree_valid),
                .tree_gnpg  (tree_gnpg),
                .tree_pp    (tree_pp),
                .tree_p     (tree_p),
                .res_valid  (res_valid),
                .res_sum    (res_sum),
                .res_cout   (res_cout)
        );

endmodule

`default_nettype wire

// File: tb_hca.sv
//**********************************************************
// Testbench of the APB hybrid prefix adder: APB driver,
// 65-bit reference model, compare tasks, random, corner,
// stall, overlap and error-response cases.
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hca_macros.svh"

module tb_hca;

        localparam int PREADY_TIMEOUT = 50;
        localparam int DONE_TIMEOUT   = 20;
        localparam int NUM_RANDOM     = 200;

        logic               clk;
        logic               rst;
        hca_pkg::apb_addr_t paddr;
        logic               psel;
        logic               penable;
        logic               pwrite;
        hca_pkg::apb_data_t pwdata;
        hca_pkg::apb_data_t prdata;
        logic               pready;
        logic               pslverr;
        integer             seed;

        hca_top DUT (
                .clk     (clk),
                .rst     (rst),
                .paddr   (paddr),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr)
        );

        always #50 clk = ~clk;

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("*** TEST FAILED ***");
                $fatal(1);
        endtask

        task automatic check_sum(input string name, input hca_pkg::operand_t exp,
                                 input hca_pkg::operand_t act);
                if (act !== exp) begin
                        report_failure($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                                                 $time, name, exp, act));
                end
        endtask

        task automatic check_word(input string name, input hca_pkg::apb_data_t exp,
                                  input hca_pkg::apb_data_t act);
                if (act !== exp) begin
                        report_failure($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                                                 $time, name, exp, act));
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        report_failure($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
                                                 $time, name, exp, act));
                end
        endtask

        task automatic check_slverr(input logic exp, input logic act);
                if (act !== exp) begin
                        report_failure($sformatf("FAIL time=%0t signal=pslverr expected=%b actual=%b",
                                                 $time, exp, act));
                end
        endtask

        // one APB transfer that starts and ends on a falling edge.
        task automatic apb_transfer(input hca_pkg::apb_addr_t addr, input logic write,
                                    input hca_pkg::apb_data_t wdata,
                                    output hca_pkg::apb_data_t rdata, output logic err,
                                    output int waits);
                paddr   = addr;
                pwrite  = write;
                pwdata  = wdata;
                psel    = 1'b1;
                penable = 1'b0;
                @(negedge clk);
                penable = 1'b1;
                waits   = 0;
                while (pready !== 1'b1) begin
                        if (waits >= PREADY_TIMEOUT) begin
                                report_failure($sformatf("pready never came for offset %h", addr));
                        end
                        @(negedge clk);
                        waits++;
                end
                rdata = prdata;
                err   = pslverr;
                @(negedge clk);         // the access completes on the rising edge before this.
                psel    = 1'b0;
                penable = 1'b0;
        endtask

        task automatic apb_write(input hca_pkg::apb_addr_t addr, input hca_pkg::apb_data_t data,
                                 output logic err);
                hca_pkg::apb_data_t unused_rdata;
                int                 waits;
                apb_transfer(addr, 1'b1, data, unused_rdata, err, waits);
        endtask

        task automatic apb_read(input hca_pkg::apb_addr_t addr, output hca_pkg::apb_data_t data,
                                output logic err, output int waits);
                apb_transfer(addr, 1'b0, '0, data, err, waits);
        endtask

        task automatic write_operands(input hca_pkg::operand_t a, input hca_pkg::operand_t b);
                logic err;
                apb_write(`HCA_REG_A_LO, a[31:0], err);
                check_slverr(1'b0, err);
                apb_write(`HCA_REG_A_HI, a[63:32], err);
                check_slverr(1'b0, err);
                apb_write(`HCA_REG_B_LO, b[31:0], err);
                check_slverr(1'b0, err);
                apb_write(`HCA_REG_B_HI, b[63:32], err);
                check_slverr(1'b0, err);
        endtask

        task automatic launch_add(input logic c);
                logic err;
                apb_write(`HCA_REG_CTRL, {30'b0, 1'b1, c}, err);
                check_slverr(1'b0, err);
        endtask

        // Reads STATUS until done, then both sum words, and checks them against the model.
        task automatic check_result(input logic [`HCA_WIDTH:0] model);
                hca_pkg::apb_data_t status;
                hca_pkg::apb_data_t lo;
                hca_pkg::apb_data_t hi;
                logic               err;
                int                 waits;
                int                 polls;
                status = '0;
                polls  = 0;
                while (status[0] !== 1'b1) begin
                        if (polls >= DONE_TIMEOUT) begin
                                report_failure("done never set in STATUS after a launch");
                        end
                        apb_read(`HCA_REG_STATUS, status, err, waits);
                        check_slverr(1'b0, err);
                        polls++;
                end
                check_flag("carry_out", model[64], status[1]);
                check_word("status", {29'b0, 1'b0, model[64], 1'b1}, status);
                apb_read(`HCA_REG_SUM_LO, lo, err, waits);
                check_slverr(1'b0, err);
                apb_read(`HCA_REG_SUM_HI, hi, err, waits);
                check_slverr(1'b0, err);
                check_sum("sum", model[63:0], {hi, lo});
        endtask

        task automatic run_add(input hca_pkg::operand_t a, input hca_pkg::operand_t b,
                               input logic c);
                logic [`HCA_WIDTH:0] model;
                model = {1'b0, a} + {1'b0, b} + {64'b0, c};
                write_operands(a, b);
                launch_add(c);
                check_result(model);
        endtask

        initial begin
                hca_pkg::operand_t   a;
                hca_pkg::operand_t   b;
                hca_pkg::apb_data_t  word;
                logic                c;
                logic                err;
                int                  waits;
                logic [`HCA_WIDTH:0] model;
                clk     = 1'b0;
                rst     = 1'b1;
                paddr   = '0;
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
                pwdata  = '0;
                seed    = 98;
                repeat (10) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;

                apb_read(`HCA_REG_STATUS, word, err, waits);
                check_word("status", '0, word);
                check_slverr(1'b0, err);
                apb_read(`HCA_REG_SUM_LO, word, err, waits);
                check_word("sum_lo", '0, word);
                apb_read(`HCA_REG_SUM_HI, word, err, waits);
                check_word("sum_hi", '0, word);

                for (int n = 0; n < NUM_RANDOM; n++) begin
                        a[63:32] = $random(seed);
                        a[31:0]  = $random(seed);
                        b[63:32] = $random(seed);
                        b[31:0]  = $random(seed);
                        word     = $random(seed);
                        c        = word[0];
                        run_add(a, b, c);
                end

                run_add('1, '0, 1'b1);          // wraps to zero with carry-out.
                run_add('1, '1, 1'b0);
                run_add('1, '1, 1'b1);
                run_add('0, '0, 1'b0);
                run_add(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b1);
                run_add(64'hAAAA_AAAA_AAAA_AAAA, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0);
                run_add(64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b1);

                // a result read right behind the launch has to wait for the new sum.
                run_add(64'h0123_4567_89AB_CDEF, 64'h1111_1111_1111_1111, 1'b0);
                a = 64'h0FED_CBA9_8765_4321;
                b = 64'h2222_2222_2222_2222;
                model = {1'b0, a} + {1'b0, b} + {64'b0, 1'b1};
                write_operands(a, b);
                launch_add(1'b1);
                apb_read(`HCA_REG_SUM_LO, word, err, waits);
                check_flag("sum_lo_stalled", 1'b1, waits > 0);
                check_word("sum_lo", model[31:0], word);
                check_result(model);

                // two launches back to back where only the second sets carry-in.
                a[63:32] = $random(seed);
                a[31:0]  = $random(seed);
                b[63:32] = $random(seed);
                b[31:0]  = $random(seed);
                model = {1'b0, a} + {1'b0, b} + {64'b0, 1'b1};
                write_operands(a, b);
                launch_add(1'b0);
                launch_add(1'b1);
                check_result(model);

                a = 64'hDEAD_0001_BEEF_0002;
                b = 64'h0BAD_0003_F00D_0004;
                write_operands(a, b);
                apb_read(8'h20, word, err, waits);
                check_slverr(1'b1, err);
                apb_write(8'h20, 32'hFFFF_FFFF, err);
                check_slverr(1'b1, err);
                apb_write(`HCA_REG_STATUS, 32'hFFFF_FFFF, err);
                check_slverr(1'b1, err);
                apb_write(`HCA_REG_SUM_LO, 32'hFFFF_FFFF, err);
                check_slverr(1'b1, err);
                apb_read(`HCA_REG_A_LO, word, err, waits);
                check_slverr(1'b0, err);
                check_word("a_lo", a[31:0], word);
                apb_read(`HCA_REG_A_HI, word, err, waits);
                check_word("a_hi", a[63:32], word);
                apb_read(`HCA_REG_B_LO, word, err, waits);
                check_word("b_lo", b[31:0], word);
                apb_read(`HCA_REG_B_HI, word, err, waits);
                check_word("b_hi", b[63:32], word);

                $display("*** TEST PASSED ***");
                $finish;
        end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
hca_pkg.sv
hca_apb_regs.sv
hca_prefix_tree.sv
hca_sum_stage.sv
hca_top.sv
tb_hca.sv

// File: Makefile
# Verilator build, lint and clean for the APB hybrid prefix adder.

TOP := tb_hca

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only -Wall +incdir+. hca_pkg.sv hca_apb_regs.sv \
		hca_prefix_tree.sv hca_sum_stage.sv hca_top.sv --top-module hca_top

clean:
	rm -rf obj_dir
